//--- hdl/exu_isa_pkg.sv
////////////////////////////////////////
// integer ISA subset of the execute stage
// data widths, operation encodings,
// operation classes and the op to class map
////////////////////////////////////////

package exu_isa_pkg;

    localparam int xlen       = 32;  // data and address width
    localparam int reg_addr_w = 5;

    // kept operations only, no load/store, div or system ops
    typedef enum logic [4:0] {
        op_add,  op_sub,  op_and,  op_or,   op_xor,
        op_sll,  op_srl,  op_sra,  op_slt,  op_sltu,
        op_beq,  op_bne,  op_blt,  op_bge,  op_bltu, op_bgeu,
        op_jal,  op_jalr,
        op_mul,  op_mulh, op_mulhu
    } exu_op_e;

    typedef enum logic [1:0] {
        class_alu,
        class_branch,  // conditional branches and jumps
        class_mul
    } exu_class_e;

    function automatic exu_class_e op_class(exu_op_e op);
        case (op)
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_jal, op_jalr:             return class_branch;
            op_mul, op_mulh, op_mulhu:   return class_mul;
            default:                     return class_alu;
        endcase
    endfunction

endpackage

//--- hdl/exu_pipe_pkg.sv
////////////////////////////////////////
// pipeline payloads of the execute stage
// commit id, routed request, writeback
// result and multiplier timing
////////////////////////////////////////

package exu_pipe_pkg;
    import exu_isa_pkg::*;

    typedef logic [3:0] commit_id_t;  // instruction tag

    // request as it leaves the dispatcher
    typedef struct packed {
        exu_op_e               op;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       a;       // rs1
        logic [xlen-1:0]       b;       // rs2 or imm, rs2 for branches
        logic [xlen-1:0]       offset;  // branch / jump offset
        logic [reg_addr_w-1:0] rd;
        commit_id_t            commit_id;
    } exu_req_t;

    // tagged register result
    typedef struct packed {
        logic [xlen-1:0]       data;
        logic [reg_addr_w-1:0] rd;
        commit_id_t            commit_id;
    } wb_res_t;

    // shift-add multiplier
    localparam int mul_steps = 32;                    // one bit per cycle
    localparam int mul_cnt_w = $clog2(mul_steps + 1);

endpackage

//--- hdl/exu_req_if.sv
////////////////////////////////////////
// routed request channel
// dispatcher to one functional unit
////////////////////////////////////////

`timescale 1ns/1ns

interface exu_req_if
    import exu_pipe_pkg::*;
(
    input logic clk
);

    logic     valid;
    logic     ready;
    exu_req_t data;   // held steady while valid and not ready

    modport disp (
        input  clk,
        output valid,
        output data,
        input  ready
    );

    modport unit (
        input  valid,
        input  data,
        output ready
    );

endinterface

//--- hdl/exu_wb_slot.sv
////////////////////////////////////////
// one-entry result holding register
// generic over the payload type
////////////////////////////////////////

`timescale 1ns/1ns

module exu_wb_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     load_i,
    input  payload_t load_data_i,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     take_i,       // writeback transfer this cycle
    output logic     free_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= 1'b1;  // load wins over a same-cycle take
        end else if (take_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            data_o <= load_data_i;
        end
    end

    // empty, or draining right now
    assign free_o = !valid_o || take_i;

    a_no_overwrite: assert property (
        @(posedge clk) disable iff (reset_i) load_i |-> free_o
    ) else $error("result slot overwritten");

    a_take_full: assert property (
        @(posedge clk) disable iff (reset_i) take_i |-> valid_o
    ) else $error("take from an empty slot");

endmodule

//--- hdl/exu_dispatch.sv
////////////////////////////////////////
// issue port handshake
// routes each instruction by class to
// the ALU/branch unit or the multiplier
////////////////////////////////////////

`timescale 1ns/1ns

module exu_dispatch
    import exu_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic                  issue_valid_i,
    output logic                  issue_ready_o,
    input  exu_op_e               issue_op_i,
    input  logic [xlen-1:0]       issue_pc_i,
    input  logic [xlen-1:0]       issue_rs1_i,
    input  logic [xlen-1:0]       issue_rs2_i,
    input  logic [xlen-1:0]       issue_imm_i,
    input  logic                  issue_use_imm_i,
    input  logic [reg_addr_w-1:0] issue_rd_i,
    input  commit_id_t            issue_commit_id_i,
    exu_req_if.disp               alu_req,
    exu_req_if.disp               mul_req
);

    exu_class_e cls;
    exu_req_t   req_d;
    logic       to_mul;

    assign cls    = op_class(issue_op_i);
    assign to_mul = (cls == class_mul);

    always_comb begin
        req_d.op        = issue_op_i;
        req_d.pc        = issue_pc_i;
        req_d.a         = issue_rs1_i;
        req_d.offset    = issue_imm_i;
        req_d.rd        = issue_rd_i;
        req_d.commit_id = issue_commit_id_i;
        // branches compare rs1 against rs2, imm only feeds the target
        if (cls == class_branch) begin
            req_d.b = issue_rs2_i;
        end else begin
            req_d.b = issue_use_imm_i ? issue_imm_i : issue_rs2_i;
        end
    end

    // same payload on both channels, valid picks the unit
    assign alu_req.data  = req_d;
    assign mul_req.data  = req_d;
    assign alu_req.valid = issue_valid_i && !to_mul;
    assign mul_req.valid = issue_valid_i && to_mul;

    assign issue_ready_o = to_mul ? mul_req.ready : alu_req.ready;

    // one instruction goes to exactly one unit
    a_one_target: assert property (
        @(posedge alu_req.clk) !(alu_req.valid && mul_req.valid)
    ) else $error("request routed to both units");

endmodule

//--- hdl/exu_alu_bru.sv
////////////////////////////////////////
// single-cycle ALU and branch unit
// result slot, registered jump redirect
////////////////////////////////////////

`timescale 1ns/1ns

module exu_alu_bru
    import exu_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    exu_req_if.unit         req,
    output logic            res_valid_o,
    output wb_res_t         res_o,
    input  logic            res_ready_i,
    output logic            jump_flag_o,
    output logic [xlen-1:0] jump_addr_o
);

    exu_req_t        r;
    wb_res_t         res_d;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] jump_sum;
    logic [xlen-1:0] target;
    logic            taken;
    logic            is_jump;
    logic            wr_en;
    logic            slot_free;
    logic            accept;

    assign r = req.data;

    always_comb begin
        case (r.op)
            op_sub:  alu_res = r.a - r.b;
            op_and:  alu_res = r.a & r.b;
            op_or:   alu_res = r.a | r.b;
            op_xor:  alu_res = r.a ^ r.b;
            op_sll:  alu_res = r.a << r.b[4:0];
            op_srl:  alu_res = r.a >> r.b[4:0];
            op_sra:  alu_res = $signed(r.a) >>> r.b[4:0];
            op_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(r.a) < $signed(r.b)};
            op_sltu: alu_res = {{(xlen-1){1'b0}}, r.a < r.b};
            default: alu_res = r.a + r.b;  // add
        endcase
    end

    always_comb begin
        case (r.op)
            op_beq:          taken = (r.a == r.b);
            op_bne:          taken = (r.a != r.b);
            op_blt:          taken = $signed(r.a) < $signed(r.b);
            op_bge:          taken = $signed(r.a) >= $signed(r.b);
            op_bltu:         taken = r.a < r.b;
            op_bgeu:         taken = r.a >= r.b;
            op_jal, op_jalr: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign is_jump  = (r.op == op_jal) || (r.op == op_jalr);
    assign jump_sum = ((r.op == op_jalr) ? r.a : r.pc) + r.offset;
    assign target   = (r.op == op_jalr) ? {jump_sum[xlen-1:1], 1'b0} : jump_sum;

    // jumps write the link value, conditional branches write nothing
    assign wr_en = (r.rd != '0) && (is_jump || op_class(r.op) == class_alu);
    assign res_d.data      = is_jump ? r.pc + 32'd4 : alu_res;
    assign res_d.rd        = r.rd;
    assign res_d.commit_id = r.commit_id;

    assign req.ready = slot_free && !jump_flag_o;  // one bubble after a redirect
    assign accept    = req.valid && req.ready;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            jump_flag_o <= 1'b0;
        end else begin
            jump_flag_o <= accept && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && taken) begin
            jump_addr_o <= target;
        end
    end

    exu_wb_slot #(.payload_t(wb_res_t)) u_slot (
        .clk        (clk),
        .reset_i    (reset_i),
        .load_i     (accept && wr_en),
        .load_data_i(res_d),
        .valid_o    (res_valid_o),
        .data_o     (res_o),
        .take_i     (res_ready_i),
        .free_o     (slot_free)
    );

    a_jump_pulse: assert property (
        @(posedge clk) disable iff (reset_i) jump_flag_o |=> !jump_flag_o
    ) else $error("jump flag held longer than one cycle");

endmodule

//--- hdl/exu_mul.sv
////////////////////////////////////////
// iterative shift-add multiplier
// mul, mulh and mulhu, one bit per cycle
////////////////////////////////////////

`timescale 1ns/1ns

module exu_mul
    import exu_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    exu_req_if.unit req,
    output logic    res_valid_o,
    output wb_res_t res_o,
    input  logic    res_ready_i
);

    exu_req_t              r;
    wb_res_t               res_d;
    logic                  busy;
    logic [mul_cnt_w-1:0]  count;
    logic [2*xlen-1:0]     mcand;
    logic [2*xlen-1:0]     acc;
    logic [2*xlen-1:0]     prod;
    logic [xlen-1:0]       mplier;
    logic [xlen-1:0]       mag_a;
    logic [xlen-1:0]       mag_b;
    logic [reg_addr_w-1:0] rd_q;
    commit_id_t            cid_q;
    logic                  high_sel;
    logic                  negate;
    logic                  signed_op;
    logic                  accept;
    logic                  last;
    logic                  finish;
    logic                  slot_free;

    assign r         = req.data;
    assign req.ready = !busy;
    assign accept    = req.valid && req.ready;

    // mulh works on magnitudes, sign restored at the end
    assign signed_op = (r.op == op_mulh);
    assign mag_a = (signed_op && r.a[xlen-1]) ? -r.a : r.a;
    assign mag_b = (signed_op && r.b[xlen-1]) ? -r.b : r.b;

    assign last   = (count == mul_cnt_w'(mul_steps));
    assign finish = busy && last && slot_free;  // waits here while the slot is full

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (accept) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy && !last) begin
            count <= count + 1'b1;
        end else if (finish) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mcand    <= {{xlen{1'b0}}, mag_a};
            mplier   <= mag_b;
            acc      <= '0;
            high_sel <= (r.op != op_mul);
            negate   <= signed_op && (r.a[xlen-1] ^ r.b[xlen-1]);
            rd_q     <= r.rd;
            cid_q    <= r.commit_id;
        end else if (busy && !last) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign prod            = negate ? -acc : acc;
    assign res_d.data      = high_sel ? prod[2*xlen-1:xlen] : prod[xlen-1:0];
    assign res_d.rd        = rd_q;
    assign res_d.commit_id = cid_q;

    exu_wb_slot #(.payload_t(wb_res_t)) u_slot (
        .clk        (clk),
        .reset_i    (reset_i),
        .load_i     (finish && rd_q != '0),  // x0 target, nothing to write
        .load_data_i(res_d),
        .valid_o    (res_valid_o),
        .data_o     (res_o),
        .take_i     (res_ready_i),
        .free_o     (slot_free)
    );

    a_busy_blocks: assert property (
        @(posedge clk) disable iff (reset_i) busy |-> !req.ready
    ) else $error("multiplier ready while busy");

endmodule

//--- hdl/exu_wb_arb.sv
////////////////////////////////////////
// writeback arbiter
// multiplier slot first, grant held
// while the core stalls writeback
////////////////////////////////////////

`timescale 1ns/1ns

module exu_wb_arb
    import exu_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  alu_valid_i,
    input  wb_res_t               alu_res_i,
    output logic                  alu_take_o,
    input  logic                  mul_valid_i,
    input  wb_res_t               mul_res_i,
    output logic                  mul_take_o,
    input  logic                  wb_ready_i,
    output logic                  wb_valid_o,
    output logic [xlen-1:0]       wb_data_o,
    output logic [reg_addr_w-1:0] wb_rd_o,
    output commit_id_t            wb_commit_id_o
);

    wb_res_t sel;
    logic    grant_mul;
    logic    hold_q;      // last cycle presented but not taken
    logic    hold_mul_q;

    // keep the old grant so a late mul result cannot swap the payload
    assign grant_mul = hold_q ? hold_mul_q : mul_valid_i;

    assign wb_valid_o = mul_valid_i || alu_valid_i;
    assign sel        = grant_mul ? mul_res_i : alu_res_i;
    assign mul_take_o = grant_mul && mul_valid_i && wb_ready_i;
    assign alu_take_o = !grant_mul && alu_valid_i && wb_ready_i;

    assign wb_data_o      = sel.data;
    assign wb_rd_o        = sel.rd;
    assign wb_commit_id_o = sel.commit_id;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_q     <= 1'b0;
            hold_mul_q <= 1'b0;
        end else begin
            hold_q     <= wb_valid_o && !wb_ready_i;
            hold_mul_q <= grant_mul;
        end
    end

    a_wb_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(sel))
    ) else $error("writeback payload changed under back-pressure");

endmodule

//--- hdl/exu_top.sv
////////////////////////////////////////
// integer execute stage top level
// dispatch, ALU/branch, multiplier and
// writeback arbiter
////////////////////////////////////////

`timescale 1ns/1ns

module exu_top
    import exu_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    // issue
    input  logic                  issue_valid_i,
    output logic                  issue_ready_o,
    input  exu_op_e               issue_op_i,
    input  logic [xlen-1:0]       issue_pc_i,
    input  logic [xlen-1:0]       issue_rs1_i,
    input  logic [xlen-1:0]       issue_rs2_i,
    input  logic [xlen-1:0]       issue_imm_i,
    input  logic                  issue_use_imm_i,
    input  logic [reg_addr_w-1:0] issue_rd_i,
    input  commit_id_t            issue_commit_id_i,
    // writeback
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output logic [xlen-1:0]       wb_data_o,
    output logic [reg_addr_w-1:0] wb_rd_o,
    output commit_id_t            wb_commit_id_o,
    // to ctrl
    output logic                  jump_flag_o,
    output logic [xlen-1:0]       jump_addr_o,
    output logic                  stall_flag_o
);

    wb_res_t alu_res;
    wb_res_t mul_res;
    logic    alu_res_valid;
    logic    mul_res_valid;
    logic    alu_take;
    logic    mul_take;

    exu_req_if alu_req (.clk(clk));
    exu_req_if mul_req (.clk(clk));

    exu_dispatch u_dispatch (
        .issue_valid_i    (issue_valid_i),
        .issue_ready_o    (issue_ready_o),
        .issue_op_i       (issue_op_i),
        .issue_pc_i       (issue_pc_i),
        .issue_rs1_i      (issue_rs1_i),
        .issue_rs2_i      (issue_rs2_i),
        .issue_imm_i      (issue_imm_i),
        .issue_use_imm_i  (issue_use_imm_i),
        .issue_rd_i       (issue_rd_i),
        .issue_commit_id_i(issue_commit_id_i),
        .alu_req          (alu_req.disp),
        .mul_req          (mul_req.disp)
    );

    exu_alu_bru u_alu_bru (
        .clk        (clk),
        .reset_i    (reset_i),
        .req        (alu_req.unit),
        .res_valid_o(alu_res_valid),
        .res_o      (alu_res),
        .res_ready_i(alu_take),
        .jump_flag_o(jump_flag_o),
        .jump_addr_o(jump_addr_o)
    );

    exu_mul u_mul (
        .clk        (clk),
        .reset_i    (reset_i),
        .req        (mul_req.unit),
        .res_valid_o(mul_res_valid),
        .res_o      (mul_res),
        .res_ready_i(mul_take)
    );

    exu_wb_arb u_wb_arb (
        .clk           (clk),
        .reset_i       (reset_i),
        .alu_valid_i   (alu_res_valid),
        .alu_res_i     (alu_res),
        .alu_take_o    (alu_take),
        .mul_valid_i   (mul_res_valid),
        .mul_res_i     (mul_res),
        .mul_take_o    (mul_take),
        .wb_ready_i    (wb_ready_i),
        .wb_valid_o    (wb_valid_o),
        .wb_data_o     (wb_data_o),
        .wb_rd_o       (wb_rd_o),
        .wb_commit_id_o(wb_commit_id_o)
    );

    assign stall_flag_o = issue_valid_i && !issue_ready_o;  // busy unit or full slot

endmodule

//--- sim/exu_tb.sv
////////////////////////////////////////
// testbench for the execute stage
// stimulus table, commit id scoreboard,
// jump, stall and back-pressure checks
////////////////////////////////////////

`timescale 1ns/1ns

module exu_tb
    import exu_isa_pkg::*;
    import exu_pipe_pkg::*;
();

    typedef struct packed {
        exu_op_e               op;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rs1;
        logic [xlen-1:0]       rs2;
        logic [xlen-1:0]       imm;
        logic                  use_imm;
        logic [reg_addr_w-1:0] rd;
        commit_id_t            cid;
        logic [xlen-1:0]       exp_data;
        logic                  exp_jump;
        logic [xlen-1:0]       exp_target;
    } test_row_t;

    logic                  clk;
    logic                  reset_i;
    logic                  issue_valid_i;
    logic                  issue_ready_o;
    exu_op_e               issue_op_i;
    logic [xlen-1:0]       issue_pc_i;
    logic [xlen-1:0]       issue_rs1_i;
    logic [xlen-1:0]       issue_rs2_i;
    logic [xlen-1:0]       issue_imm_i;
    logic                  issue_use_imm_i;
    logic [reg_addr_w-1:0] issue_rd_i;
    commit_id_t            issue_commit_id_i;
    logic                  wb_valid_o;
    logic                  wb_ready_i;
    logic [xlen-1:0]       wb_data_o;
    logic [reg_addr_w-1:0] wb_rd_o;
    commit_id_t            wb_commit_id_o;
    logic                  jump_flag_o;
    logic [xlen-1:0]       jump_addr_o;
    logic                  stall_flag_o;

    test_row_t             rows[$];
    int                    pending[16];       // row index per commit id or -1
    int                    outstanding;
    int                    cur_row;           // row presented on the issue port
    int                    error_count;
    int                    wb_count;
    int                    mul_stall_cycles;
    int                    mul_age;           // cycles since the last multiply was accepted
    int                    last_wb_row;
    int                    cycle_count;
    int                    cycle_limit;
    bit                    ooo_seen;
    bit                    jump_exp;
    logic [xlen-1:0]       jump_target;
    bit                    hold_q;
    logic [xlen-1:0]       held_data;
    logic [reg_addr_w-1:0] held_rd;
    commit_id_t            held_cid;

    exu_top DUT (.*);

    always #5 clk = ~clk;

    // roughly 40 % of cycles stall the writeback
    always @(posedge clk) begin
        wb_ready_i <= ($urandom % 5) > 1;
    end

    function automatic void add_row(exu_op_e op, logic [31:0] pc, logic [31:0] rs1,
                                    logic [31:0] rs2, logic [31:0] imm, logic use_imm,
                                    logic [4:0] rd, logic [3:0] cid, logic [31:0] data,
                                    logic jump, logic [31:0] target);
        test_row_t r;
        r = '{op, pc, rs1, rs2, imm, use_imm, rd, cid, data, jump, target};
        rows.push_back(r);
    endfunction

    // neither conditional branches nor x0 get written
    function automatic bit expects_wb(test_row_t r);
        bit cond_branch;
        cond_branch = r.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
        return (r.rd != 5'd0) && !cond_branch;
    endfunction

    task automatic build_table();
        // alu ops in register and immediate form
        add_row(op_add,  0, 5, 7, 0, 0, 1, 0, 12, 0, 0);
        add_row(op_sub,  0, 3, 10, 0, 0, 2, 1, 32'hffff_fff9, 0, 0);
        add_row(op_and,  0, 32'hf0f0_1234, 0, 32'h0000_0ff0, 1, 3, 2, 32'h0000_0230, 0, 0);
        add_row(op_or,   0, 32'h1200_0000, 32'h34, 0, 0, 4, 3, 32'h1200_0034, 0, 0);
        add_row(op_xor,  0, 32'hffff_0000, 0, 32'hffff_ffff, 1, 5, 4, 32'h0000_ffff, 0, 0);
        add_row(op_sll,  0, 1, 0, 31, 1, 6, 5, 32'h8000_0000, 0, 0);
        add_row(op_srl,  0, 32'h8000_0000, 4, 0, 0, 7, 6, 32'h0800_0000, 0, 0);
        add_row(op_sra,  0, 32'h8000_0000, 4, 0, 0, 8, 7, 32'hf800_0000, 0, 0);
        add_row(op_sra,  0, 32'hffff_ff00, 32'h24, 0, 0, 9, 8, 32'hffff_fff0, 0, 0);
        add_row(op_slt,  0, 32'hffff_ffff, 1, 0, 0, 10, 9, 1, 0, 0);
        add_row(op_sltu, 0, 32'hffff_ffff, 1, 0, 0, 11, 10, 0, 0, 0);
        add_row(op_slt,  0, 5, 0, 32'hffff_fffd, 1, 12, 11, 0, 0, 0);
        add_row(op_add,  0, 1, 2, 0, 0, 0, 12, 3, 0, 0);
        // taken and not taken conditional branches
        add_row(op_beq,  32'h1000, 9, 9, 32'h20, 0, 3, 13, 0, 1, 32'h1020);
        add_row(op_beq,  32'h1004, 9, 8, 32'h20, 0, 3, 14, 0, 0, 0);
        add_row(op_bne,  32'h1100, 1, 2, 32'hffff_fff0, 0, 3, 15, 0, 1, 32'h10f0);
        add_row(op_bne,  32'h1104, 4, 4, 32'h20, 0, 3, 0, 0, 0, 0);
        add_row(op_blt,  32'h1200, 32'hffff_fffb, 3, 32'h40, 0, 3, 1, 0, 1, 32'h1240);
        add_row(op_blt,  32'h1204, 3, 32'hffff_fffb, 32'h40, 0, 3, 2, 0, 0, 0);
        add_row(op_bge,  32'h1300, 32'h7fff_ffff, 32'h8000_0000, 8, 0, 3, 3, 0, 1, 32'h1308);
        add_row(op_bge,  32'h1304, 32'h8000_0000, 0, 8, 0, 3, 4, 0, 0, 0);
        add_row(op_bltu, 32'h1400, 1, 32'hffff_ffff, 32'h100, 0, 3, 5, 0, 1, 32'h1500);
        add_row(op_bltu, 32'h1404, 32'hffff_ffff, 1, 32'h100, 0, 3, 6, 0, 0, 0);
        add_row(op_bgeu, 32'h1500, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ff00, 0, 3, 7,
                0, 1, 32'h1400);
        add_row(op_bgeu, 32'h1504, 2, 3, 32'h10, 0, 3, 8, 0, 0, 0);
        // jumps write pc+4
        add_row(op_jal,  32'h2000, 0, 0, 32'h100, 0, 1, 9, 32'h2004, 1, 32'h2100);
        add_row(op_jalr, 32'h2100, 32'h3003, 0, 32'h10, 0, 2, 10, 32'h2104, 1, 32'h3012);
        add_row(op_jalr, 32'h2200, 32'h4000, 0, 32'hffff_ffff, 0, 0, 11, 32'h2204, 1,
                32'h3ffe);
        // multiplier on signed extremes
        add_row(op_mul,   0, 32'h8000_0000, 32'hffff_ffff, 0, 0, 14, 12, 32'h8000_0000, 0, 0);
        add_row(op_mulh,  0, 32'h8000_0000, 32'hffff_ffff, 0, 0, 15, 13, 32'h0000_0000, 0, 0);
        add_row(op_mulhu, 0, 32'h8000_0000, 32'hffff_ffff, 0, 0, 16, 14, 32'h7fff_ffff, 0, 0);
        add_row(op_mulh,  0, 32'hffff_fffd, 5, 0, 0, 18, 15, 32'hffff_ffff, 0, 0);
        add_row(op_mulhu, 0, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 19, 0, 32'hffff_fffe, 0, 0);
        // mul, an add that overtakes it and a mul that stalls issue
        add_row(op_mul,   0, 7, 6, 0, 0, 21, 1, 32'h2a, 0, 0);
        add_row(op_add,   0, 100, 23, 0, 0, 22, 2, 32'h7b, 0, 0);
        add_row(op_mulhu, 0, 32'h0001_0000, 32'h0001_0000, 0, 0, 23, 3, 1, 0, 0);
    endtask

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("check failed: %s", msg);
    endtask

    task automatic issue_row(input int idx);
        test_row_t r;
        r = rows[idx];
        cur_row           <= idx;
        issue_valid_i     <= 1'b1;
        issue_op_i        <= r.op;
        issue_pc_i        <= r.pc;
        issue_rs1_i       <= r.rs1;
        issue_rs2_i       <= r.rs2;
        issue_imm_i       <= r.imm;
        issue_use_imm_i   <= r.use_imm;
        issue_rd_i        <= r.rd;
        issue_commit_id_i <= r.cid;
        do begin
            @(posedge clk);
        end while (!issue_ready_o);
    endtask

    task automatic check_writeback();
        int row;
        row = pending[wb_commit_id_o];
        wb_count++;
        assert (row >= 0) else
            report_failure($sformatf("writeback for commit id %0d that is not in flight",
                                     wb_commit_id_o));
        if (row >= 0) begin
            assert (wb_data_o == rows[row].exp_data) else
                report_mismatch($sformatf("row %0d data %h, expected %h",
                                          row, wb_data_o, rows[row].exp_data));
            assert (wb_rd_o == rows[row].rd) else
                report_mismatch($sformatf("row %0d rd %0d, expected %0d",
                                          row, wb_rd_o, rows[row].rd));
            pending[wb_commit_id_o] = -1;
            outstanding--;
            if (row < last_wb_row) begin
                ooo_seen = 1'b1;
            end else begin
                last_wb_row = row;
            end
        end
    endtask

    task automatic accept_row(input int idx);
        test_row_t r;
        r = rows[idx];
        jump_exp    = r.exp_jump;
        jump_target = r.exp_target;
        if (r.op inside {op_mul, op_mulh, op_mulhu}) begin
            mul_age = 0;
        end
        if (expects_wb(r)) begin
            assert (pending[r.cid] < 0) else
                report_failure($sformatf("commit id %0d reused while in flight", r.cid));
            pending[r.cid] = idx;
            outstanding++;
        end
    endtask

    // scoreboard and per-cycle protocol checks
    always @(posedge clk) begin
        if (!reset_i) begin
            if (wb_valid_o && wb_ready_i) begin
                check_writeback();
            end
            if (hold_q) begin
                assert (wb_valid_o && wb_data_o == held_data && wb_rd_o == held_rd
                        && wb_commit_id_o == held_cid) else
                    report_failure("writeback dropped or changed while stalled");
            end
            hold_q    = wb_valid_o && !wb_ready_i;
            held_data = wb_data_o;
            held_rd   = wb_rd_o;
            held_cid  = wb_commit_id_o;
            assert (jump_flag_o == jump_exp) else
                report_mismatch($sformatf("jump flag %b, expected %b", jump_flag_o, jump_exp));
            if (jump_exp) begin
                assert (jump_addr_o == jump_target) else
                    report_mismatch($sformatf("jump target %h, expected %h",
                                              jump_addr_o, jump_target));
            end
            mul_age++;
            // multiplier stays busy for mul_steps+1 cycles after acceptance
            if (issue_valid_i && rows[cur_row].op inside {op_mul, op_mulh, op_mulhu}
                    && mul_age <= mul_steps + 1) begin
                assert (stall_flag_o) else
                    report_mismatch($sformatf("stall flag low %0d cycles after a multiply",
                                              mul_age));
            end
            if (!issue_valid_i || issue_ready_o) begin
                assert (!stall_flag_o) else
                    report_mismatch("stall flag high while issue is not blocked");
            end
            if (stall_flag_o && issue_op_i inside {op_mul, op_mulh, op_mulhu}) begin
                mul_stall_cycles++;
            end
            jump_exp = 1'b0;
            if (issue_valid_i && issue_ready_o) begin
                accept_row(cur_row);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, %0d results still in flight",
                     cycle_count, outstanding);
            $display("errors: %0d", error_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hca28));
        build_table();
        cycle_limit = rows.size() * 40 + 100;
        for (int i = 0; i < 16; i++) begin
            pending[i] = -1;
        end
        last_wb_row       = -1;
        mul_age           = mul_steps + 2;
        clk               = 1'b0;
        reset_i           = 1'b1;
        issue_valid_i     = 1'b0;
        issue_op_i        = op_add;
        issue_pc_i        = '0;
        issue_rs1_i       = '0;
        issue_rs2_i       = '0;
        issue_imm_i       = '0;
        issue_use_imm_i   = 1'b0;
        issue_rd_i        = '0;
        issue_commit_id_i = '0;
        wb_ready_i        = 1'b0;

        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            issue_row(i);
        end
        issue_valid_i <= 1'b0;

        // scoreboard has seen the last acceptance by the next falling edge
        do begin
            @(negedge clk);
        end while (outstanding != 0);
        repeat (4) @(posedge clk);  // catch late duplicates

        assert (ooo_seen) else
            report_failure("no result completed out of issue order");
        assert (mul_stall_cycles > 0) else
            report_failure("issue never stalled behind the multiplier");

        $display("errors: %0d, writebacks: %0d, multiplier stall cycles: %0d",
                 error_count, wb_count, mul_stall_cycles);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
hdl/exu_isa_pkg.sv
hdl/exu_pipe_pkg.sv
hdl/exu_req_if.sv
hdl/exu_wb_slot.sv
hdl/exu_dispatch.sv
hdl/exu_alu_bru.sv
hdl/exu_mul.sv
hdl/exu_wb_arb.sv
hdl/exu_top.sv
sim/exu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the execute stage testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module exu_tb -o exu_tb_sim \
    && ./obj_dir/exu_tb_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
